/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module conv_tb -f list.f -o conv_sim
	./obj_dir/conv_sim | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then \
	  echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "TEST PASS" sim.log; then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* dv/conv_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_properties
  import conv_pkg::*;
(
  input wire logic clock,
  input wire logic rst_n,
  input wire logic go,
  input wire logic finish,
  input wire logic image_enable,
  input wire logic filter_enable,
  input wire logic tap_last,
  input wire logic result_valid,
  input wire logic output_write
);

  logic [TAP_W-1:0] fetch_count;

  // Filter reads seen since reset, stops at a full filter
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      fetch_count <= '0;
    end else if (filter_enable && (fetch_count != TAP_W'(TAP_COUNT))) begin
      fetch_count <= fetch_count + 1'b1;
    end
  end

  // Cached filter means no more memory reads
  a_no_fetch_when_filled: assert property (
    @(posedge clock) disable iff (!rst_n)
      (fetch_count == TAP_W'(TAP_COUNT)) |-> !filter_enable
  ) else $error("filter memory read after the whole filter was cached");

  a_result_after_last_tap: assert property (
    @(posedge clock) disable iff (!rst_n) result_valid == $past(tap_last, 2)
  ) else $error("result_valid not two cycles after the last tap");

  // One cycle behind result_valid
  a_write_after_result: assert property (
    @(posedge clock) disable iff (!rst_n) output_write == $past(tap_last, 3)
  ) else $error("output_write not one cycle after result_valid");

  // Finish only clears on an accepted go
  a_finish_held: assert property (
    @(posedge clock) disable iff (!rst_n) $fell(finish) |-> $past(go) && image_enable
  ) else $error("finish fell without an accepted go");

endmodule

`default_nettype wire

/* dv/conv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_tb
  import conv_pkg::*;
;

  localparam int ROWS = 5;
  localparam int RUN_CYCLES = 148;
  localparam int PERIOD = 8;
  localparam int TIMEOUT_NS = 2 * (ROWS * RUN_CYCLES + ROWS * 8) * PERIOD;

  logic clock = 1'b0;
  logic rst_n;
  logic go;
  logic finish;
  logic [IMAGE_ADDR_W-1:0] image_address;
  logic image_enable;
  logic [DATA_W-1:0] image_data;
  logic [FILTER_ADDR_W-1:0] filter_address;
  logic filter_enable;
  logic [DATA_W-1:0] filter_data;
  logic [OUTPUT_ADDR_W-1:0] output_address;
  logic [DATA_W-1:0] output_data;
  logic output_write;

  // Stimulus table
  logic              reset_before [ROWS];
  logic              mid_go [ROWS];
  logic [31:0]       image_seed [ROWS];
  logic [DATA_W-1:0] filter_table [ROWS][TAP_COUNT];
  logic [DATA_W-1:0] image_table [ROWS][256];
  logic [DATA_W-1:0] expected [ROWS][TILE_COUNT];

  logic [DATA_W-1:0] image_mem [256];
  logic [DATA_W-1:0] filter_mem [16];
  logic [DATA_W-1:0] captured [TILE_COUNT];

  int error_count = 0;
  int check_count = 0;
  int write_total = 0;
  int fetch_total = 0;

  always #(PERIOD / 2) clock = ~clock;

  conv_top UUT (.*);

  bind conv_top conv_properties u_properties (
    .clock         (clock),
    .rst_n         (rst_n),
    .go            (go),
    .finish        (finish),
    .image_enable  (image_enable),
    .filter_enable (filter_enable),
    .tap_last      (tap_last),
    .result_valid  (result_valid),
    .output_write  (output_write)
  );

  // --------------------------------------------------
  // Memory models and monitors
  // --------------------------------------------------
  always @(posedge clock) begin
    if (image_enable) image_data <= image_mem[image_address];
    if (filter_enable) filter_data <= filter_mem[filter_address];
  end

  always @(posedge clock) begin
    if (rst_n && output_write) begin
      compare(32'(output_address), 32'(write_total % TILE_COUNT), "output write order");
      captured[output_address] = output_data;
      write_total = write_total + 1;
    end
    if (rst_n && filter_enable) fetch_total = fetch_total + 1;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare(input logic [31:0] got, input logic [31:0] want, input string msg);
    check_count = check_count + 1;
    if (got !== want) begin
      error_count = error_count + 1;
      $display("ERROR at %0t: %s, got %0h, expected %0h", $time, msg, got, want);
    end
  endtask

  // Clamped upper half of the wrapped sum over one tile
  function automatic logic [DATA_W-1:0] tile_result(input int row, input int t,
                                                     input logic [DATA_W-1:0] f [TAP_COUNT]);
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] a;
    logic signed [ACC_W-1:0] b;
    int addr;
    acc = 0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        addr = (3 * (t / 4) + r) * 16 + 3 * (t % 4) + c;
        a = $signed(image_table[row][addr]);
        b = $signed(f[r * 3 + c]);
        acc = acc + a * b;
      end
    end
    if (acc < 0) begin
      return '0;
    end
    return DATA_W'(acc >>> DATA_W);
  endfunction

  task automatic apply_reset();
    @(posedge clock);
    rst_n <= 1'b0;
    repeat (8) @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);
    compare(32'(finish), 0, "finish low after reset");
  endtask

  task automatic run_row(input int row);
    int cycles;
    int write_base;
    int fetch_base;
    image_mem = image_table[row];
    for (int i = 0; i < 16; i++) begin
      filter_mem[i] = (i < TAP_COUNT) ? filter_table[row][i] : DATA_W'(16'h5a00 + i);
    end
    write_base = write_total;
    fetch_base = fetch_total;
    @(posedge clock);
    go <= 1'b1;
    @(posedge clock);
    go <= 1'b0;
    cycles = 1;
    @(negedge clock);
    compare(32'(finish), 0, "finish drops after go");
    while (!finish) begin
      if (mid_go[row] && cycles == 70) begin
        @(posedge clock);
        go <= 1'b1;
        @(posedge clock);
        go <= 1'b0;
        @(negedge clock);
        cycles = cycles + 2;
      end else begin
        @(negedge clock);
        cycles = cycles + 1;
      end
    end
    compare(32'(cycles), RUN_CYCLES, "cycles from go to finish");
    compare(32'(write_total - write_base), TILE_COUNT, "writes per run");
    compare(32'(fetch_total - fetch_base), reset_before[row] ? TAP_COUNT : 0,
            "filter memory reads per run");
    for (int t = 0; t < TILE_COUNT; t++) begin
      compare(32'(captured[t]), 32'(expected[row][t]), $sformatf("row %0d tile %0d", row, t));
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Run timed out before all rows completed");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    logic [DATA_W-1:0] cached [TAP_COUNT];
    logic [31:0] state;
    rst_n = 1'b0;
    go = 1'b0;
    image_data = '0;
    filter_data = '0;

    reset_before = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    mid_go = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
    image_seed = '{32'h1, 32'h2, 32'h3, 32'h4, 32'h5};
    filter_table[0] = '{16'd12000, -16'sd8000, 16'd20000, 16'd31000, -16'sd32768,
                        16'd5000, -16'sd17000, 16'd9000, 16'd26000};
    filter_table[1] = '{16'd100, 16'd200, 16'd300, 16'd400, 16'd500,
                        16'd600, 16'd700, 16'd800, 16'd900};
    // Mostly negative filter
    filter_table[2] = '{-16'sd30000, -16'sd25000, -16'sd12000, 16'd4000, -16'sd28000,
                        -16'sd9000, -16'sd21000, 16'd7000, -16'sd15000};
    filter_table[3] = '{16'd1, 16'd2, 16'd3, 16'd4, 16'd5, 16'd6, 16'd7, 16'd8, 16'd9};
    // Extremes to make the accumulator wrap
    filter_table[4] = '{16'h7fff, 16'h8000, 16'h7fff, 16'h8000, 16'h7fff,
                        16'h8000, 16'h7fff, 16'h8000, 16'h7fff};

    // --------------------------------------------------
    // Expected values
    // --------------------------------------------------
    for (int row = 0; row < ROWS; row++) begin
      state = 32'h02ca_d56e ^ image_seed[row];
      for (int a = 0; a < 256; a++) begin
        state = xorshift(state);
        image_table[row][a] = state[DATA_W-1:0];
      end
      if (reset_before[row]) cached = filter_table[row];
      for (int t = 0; t < TILE_COUNT; t++) begin
        expected[row][t] = tile_result(row, t, cached);
      end
    end

    for (int row = 0; row < ROWS; row++) begin
      if (reset_before[row]) apply_reset();
      run_row(row);
    end

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
source/conv_pkg.sv
source/window_sequencer.sv
source/filter_cache.sv
source/tile_mac.sv
source/output_writer.sv
source/conv_top.sv
dv/conv_properties.sv
dv/conv_tb.sv

/* source/conv_pkg.sv */
`default_nettype none

package conv_pkg;

  // ------------------------------------------------
  // Data widths
  // ------------------------------------------------
  localparam int DATA_W = 16;
  localparam int ACC_W = 32;

  // ------------------------------------------------
  // Tile geometry
  // ------------------------------------------------
  localparam int WINDOW_DIM = 3;
  localparam int TAP_COUNT = 9;
  localparam int TAP_W = 4;

  localparam int TILES_PER_SIDE = 4;
  localparam int TILE_COUNT = 16;
  localparam int TILE_W = 4;

  // ------------------------------------------------
  // Memory addresses
  // ------------------------------------------------
  // Image address is {row, column}, one nibble each
  localparam int IMAGE_ADDR_W = 8;
  localparam int FILTER_ADDR_W = 4;
  localparam int OUTPUT_ADDR_W = 4;

endpackage

`default_nettype wire

/* source/conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_top
  import conv_pkg::*;
(
  input  wire logic                     clock,
  input  wire logic                     rst_n,
  input  wire logic                     go,
  output logic                          finish,
  output logic [IMAGE_ADDR_W-1:0]       image_address,
  output logic                          image_enable,
  input  wire logic [DATA_W-1:0]        image_data,
  output logic [FILTER_ADDR_W-1:0]      filter_address,
  output logic                          filter_enable,
  input  wire logic [DATA_W-1:0]        filter_data,
  output logic [OUTPUT_ADDR_W-1:0]      output_address,
  output logic [DATA_W-1:0]             output_data,
  output logic                          output_write
);

  // ------------------------------------------------
  // Tap strobes
  // ------------------------------------------------
  logic             tap_valid;
  logic [TAP_W-1:0] tap_index;
  logic             tap_first;
  logic             tap_last;

  // ------------------------------------------------
  // Datapath
  // ------------------------------------------------
  logic [DATA_W-1:0] filter_tap;
  logic [DATA_W-1:0] result;
  logic              result_valid;

  window_sequencer u_sequencer (
    .clock         (clock),
    .rst_n         (rst_n),
    .go            (go),
    .finish        (finish),
    .image_address (image_address),
    .image_enable  (image_enable),
    .tap_valid     (tap_valid),
    .tap_index     (tap_index),
    .tap_first     (tap_first),
    .tap_last      (tap_last)
  );

  filter_cache u_filter_cache (
    .clock          (clock),
    .rst_n          (rst_n),
    .tap_valid      (tap_valid),
    .tap_index      (tap_index),
    .filter_data    (filter_data),
    .filter_address (filter_address),
    .filter_enable  (filter_enable),
    .filter_tap     (filter_tap)
  );

  tile_mac u_tile_mac (
    .clock        (clock),
    .rst_n        (rst_n),
    .tap_valid    (tap_valid),
    .tap_first    (tap_first),
    .tap_last     (tap_last),
    .image_data   (image_data),
    .filter_tap   (filter_tap),
    .result       (result),
    .result_valid (result_valid)
  );

  output_writer u_output_writer (
    .clock          (clock),
    .rst_n          (rst_n),
    .go             (go),
    .result         (result),
    .result_valid   (result_valid),
    .output_address (output_address),
    .output_data    (output_data),
    .output_write   (output_write),
    .finish         (finish)
  );

endmodule

`default_nettype wire

/* source/filter_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module filter_cache
  import conv_pkg::*;
(
  input  wire logic                     clock,
  input  wire logic                     rst_n,
  input  wire logic                     tap_valid,
  input  wire logic [TAP_W-1:0]         tap_index,
  input  wire logic [DATA_W-1:0]        filter_data,
  output logic [FILTER_ADDR_W-1:0]      filter_address,
  output logic                          filter_enable,
  output logic [DATA_W-1:0]             filter_tap
);

  logic [DATA_W-1:0] tap_file [TAP_COUNT];
  logic              filled;
  logic              fetch_d;
  logic [TAP_W-1:0]  index_d;
  logic [DATA_W-1:0] read_q;

  // Memory is only read until all nine taps are held
  assign filter_enable  = tap_valid && !filled;
  assign filter_address = FILTER_ADDR_W'(tap_index);

  // Fresh memory word during the fetch, cached copy afterwards
  assign filter_tap = fetch_d ? filter_data : read_q;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      fetch_d <= 1'b0;
      filled  <= 1'b0;
    end else begin
      fetch_d <= filter_enable;
      if (filter_enable && (tap_index == TAP_W'(TAP_COUNT - 1))) begin
        filled <= 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // Register file
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    index_d <= tap_index;
    if (fetch_d) begin
      tap_file[index_d] <= filter_data;
    end
    if (tap_valid && filled) begin
      read_q <= tap_file[tap_index];
    end
  end

endmodule

`default_nettype wire

/* source/output_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module output_writer
  import conv_pkg::*;
(
  input  wire logic                     clock,
  input  wire logic                     rst_n,
  input  wire logic                     go,
  input  wire logic [DATA_W-1:0]        result,
  input  wire logic                     result_valid,
  output logic [OUTPUT_ADDR_W-1:0]      output_address,
  output logic [DATA_W-1:0]             output_data,
  output logic                          output_write,
  output logic                          finish
);

  logic [TILE_W-1:0] tile_count;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      output_write   <= 1'b0;
      output_address <= '0;
      tile_count     <= '0;
      finish         <= 1'b0;
    end else begin
      output_write <= result_valid;
      if (result_valid) begin
        output_address <= OUTPUT_ADDR_W'(tile_count);
        tile_count     <= tile_count + 1'b1;
      end

      // Last tile written, hold until the next run starts
      if (output_write && (output_address == OUTPUT_ADDR_W'(TILE_COUNT - 1))) begin
        finish <= 1'b1;
      end else if (go) begin
        finish <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (result_valid) begin
      output_data <= result;
    end
  end

endmodule

`default_nettype wire

/* source/tile_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_mac
  import conv_pkg::*;
(
  input  wire logic                      clock,
  input  wire logic                      rst_n,
  input  wire logic                      tap_valid,
  input  wire logic                      tap_first,
  input  wire logic                      tap_last,
  input  wire logic signed [DATA_W-1:0]  image_data,
  input  wire logic signed [DATA_W-1:0]  filter_tap,
  output logic [DATA_W-1:0]              result,
  output logic                           result_valid
);

  logic valid_d;
  logic first_d;
  logic last_d;

  logic signed [ACC_W-1:0] product;
  logic signed [ACC_W-1:0] acc;
  logic signed [ACC_W-1:0] sum;

  assign product = image_data * filter_tap;

  // Wraps on overflow
  assign sum = first_d ? product : acc + product;

  // ------------------------------------------------
  // Strobes, one cycle late to meet the memory data
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      valid_d      <= 1'b0;
      first_d      <= 1'b0;
      last_d       <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      valid_d      <= tap_valid;
      first_d      <= tap_valid && tap_first;
      last_d       <= tap_valid && tap_last;
      result_valid <= valid_d && last_d;
    end
  end

  // ------------------------------------------------
  // Accumulate and clamp
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    if (valid_d) begin
      acc <= sum;
    end
    if (valid_d && last_d) begin
      // Negative sums clamp to zero, else keep the upper half
      result <= sum[ACC_W-1] ? '0 : sum[ACC_W-1 -: DATA_W];
    end
  end

endmodule

`default_nettype wire

/* source/window_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module window_sequencer
  import conv_pkg::*;
(
  input  wire logic                    clock,
  input  wire logic                    rst_n,
  input  wire logic                    go,
  input  wire logic                    finish,
  output logic [IMAGE_ADDR_W-1:0]      image_address,
  output logic                         image_enable,
  output logic                         tap_valid,
  output logic [TAP_W-1:0]             tap_index,
  output logic                         tap_first,
  output logic                         tap_last
);

  logic running;
  logic draining;
  logic start;
  logic issue;

  logic [TILE_W-1:0] tile;
  logic [1:0]        row_off;
  logic [1:0]        col_off;

  logic col_end;
  logic row_end;
  logic tile_end;
  logic last_tap;

  logic [IMAGE_ADDR_W/2-1:0] row_base;
  logic [IMAGE_ADDR_W/2-1:0] col_base;
  logic [IMAGE_ADDR_W/2-1:0] row;
  logic [IMAGE_ADDR_W/2-1:0] col;

  // Go only while idle, and not before the previous run has finished
  assign start = go && !running && (!draining || finish);
  assign issue = start || running;

  assign col_end  = (col_off == 2'(WINDOW_DIM - 1));
  assign row_end  = (row_off == 2'(WINDOW_DIM - 1));
  assign tile_end = (tile == TILE_W'(TILE_COUNT - 1));
  assign last_tap = col_end && row_end && tile_end;

  // Tiles in raster order
  assign row_base = (IMAGE_ADDR_W/2)'((tile / TILES_PER_SIDE) * WINDOW_DIM);
  assign col_base = (IMAGE_ADDR_W/2)'((tile % TILES_PER_SIDE) * WINDOW_DIM);
  assign row = row_base + (IMAGE_ADDR_W/2)'(row_off);
  assign col = col_base + (IMAGE_ADDR_W/2)'(col_off);

  // ------------------------------------------------
  // Run level and tap walk
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      running      <= 1'b0;
      draining     <= 1'b0;
      image_enable <= 1'b0;
      tap_valid    <= 1'b0;
      tap_first    <= 1'b0;
      tap_last     <= 1'b0;
      tile         <= '0;
      row_off      <= '0;
      col_off      <= '0;
    end else begin
      image_enable <= issue;
      tap_valid    <= issue;
      tap_first    <= issue && (row_off == 2'd0) && (col_off == 2'd0);
      tap_last     <= issue && row_end && col_end;

      if (issue) begin
        running <= !last_tap;
        if (col_end) begin
          col_off <= '0;
          if (row_end) begin
            row_off <= '0;
            tile    <= tile + 1'b1;
          end else begin
            row_off <= row_off + 1'b1;
          end
        end else begin
          col_off <= col_off + 1'b1;
        end
      end

      // Held until the writer reports the last result
      if (issue && last_tap) begin
        draining <= 1'b1;
      end else if (finish) begin
        draining <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      image_address <= {row, col};
      tap_index     <= TAP_W'(row_off * WINDOW_DIM + col_off);
    end
  end

endmodule

`default_nettype wire
